// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := i2s_pwm_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/audio_pkg.sv
package audio_pkg;

    //////////////////////////////////////////////////
    // Sample format
    //////////////////////////////////////////////////

    // Parallel sample and receive shift register width
    localparam int SAMPLE_BITS = 24;

    //////////////////////////////////////////////////
    // Channel routing
    //////////////////////////////////////////////////

    // Output channel mode, driven from a plain pin
    typedef enum logic [1:0] {
        // Left to left, right to right
        MODE_STEREO = 2'd0,
        // Left and right exchanged
        MODE_SWAP   = 2'd1,
        // Floor of signed mean on both outputs
        MODE_MONO   = 2'd2
    } chan_mode_t;

endpackage

// File: hw/i2s_pwm_top.sv
`timescale 1ns/1ns

module i2s_pwm_top #(
    parameter int PWM_BITS = 8
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     bclk,
    input  logic                                     lrclk,
    input  logic                                     sdata,
    input  audio_pkg::chan_mode_t                    mode,
    output logic                                     frame_valid,
    output logic signed [audio_pkg::SAMPLE_BITS-1:0] out_l,
    output logic signed [audio_pkg::SAMPLE_BITS-1:0] out_r,
    output logic [7:0]                               word_bits,
    output logic                                     pwm_l,
    output logic                                     pwm_r
);
    import audio_pkg::*;

    // Receiver to aligner
    logic                   l_valid;
    logic                   r_valid;
    logic [SAMPLE_BITS-1:0] word;

    // Serial I2S in, words with bit counts out
    i2s_rx i_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .sdata     (sdata),
        .l_valid   (l_valid),
        .r_valid   (r_valid),
        .word      (word),
        .word_bits (word_bits)
    );

    // Left-justify and channel mode
    sample_align i_align (
        .clk         (clk),
        .arst_n      (arst_n),
        .l_valid     (l_valid),
        .r_valid     (r_valid),
        .word        (word),
        .word_bits   (word_bits),
        .mode        (mode),
        .frame_valid (frame_valid),
        .out_l       (out_l),
        .out_r       (out_r)
    );

    // Two PWM pins from one counter
    pwm_modulator #(
        .PWM_BITS (PWM_BITS)
    ) i_pwm (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_valid (frame_valid),
        .in_l        (out_l),
        .in_r        (out_r),
        .pwm_l       (pwm_l),
        .pwm_r       (pwm_r)
    );

endmodule

// File: hw/i2s_rx.sv
`timescale 1ns/1ns

module i2s_rx (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              bclk,
    input  logic                              lrclk,
    input  logic                              sdata,
    output logic                              l_valid,
    output logic                              r_valid,
    output logic [audio_pkg::SAMPLE_BITS-1:0] word,
    output logic [7:0]                        word_bits
);
    import audio_pkg::*;

    //////////////////////////////////////////////////
    // Input synchronizers
    //////////////////////////////////////////////////

    // Bit order {bclk, lrclk, sdata}
    logic [2:0] sync_1;
    logic [2:0] sync_2;
    // Third bclk stage for edge detect
    logic       bclk_d3;
    logic       bclk_en;

    logic       bclk_s;
    logic       lrclk_s;
    logic       sdata_s;

    assign bclk_s  = sync_2[2];
    assign lrclk_s = sync_2[1];
    assign sdata_s = sync_2[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_1  <= 3'b000;
            sync_2  <= 3'b000;
            bclk_d3 <= 1'b0;
            bclk_en <= 1'b0;
        end else begin
            sync_1  <= {bclk, lrclk, sdata};
            sync_2  <= sync_1;
            bclk_d3 <= bclk_s;
            // One clk enable per bclk rising edge
            bclk_en <= bclk_s & ~bclk_d3;
        end
    end

    //////////////////////////////////////////////////
    // Shift register and bit counter
    //////////////////////////////////////////////////

    logic                   lrclk_prev;
    logic [7:0]             bit_cnt;
    logic [7:0]             cnt_inc;
    logic [SAMPLE_BITS-1:0] shift_reg;
    logic [SAMPLE_BITS-1:0] shift_next;
    logic                   lr_change;

    // New bit enters at the low end
    assign shift_next = {shift_reg[SAMPLE_BITS-2:0], sdata_s};
    // Counter sticks at 255 for very long words
    assign cnt_inc    = (bit_cnt == 8'hff) ? 8'hff : bit_cnt + 8'd1;
    // Word boundary, this edge still carries the ending word's last bit
    assign lr_change  = lrclk_s != lrclk_prev;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lrclk_prev <= 1'b0;
            bit_cnt    <= 8'd0;
            word_bits  <= 8'd0;
            l_valid    <= 1'b0;
            r_valid    <= 1'b0;
        end else begin
            l_valid <= 1'b0;
            r_valid <= 1'b0;
            if (bclk_en) begin
                lrclk_prev <= lrclk_s;
                if (lr_change) begin
                    // Count includes the bit just taken
                    word_bits <= cnt_inc;
                    bit_cnt   <= 8'd0;
                    // Word finished while lrclk low is left
                    l_valid   <= ~lrclk_prev;
                    r_valid   <= lrclk_prev;
                end else begin
                    bit_cnt <= cnt_inc;
                end
            end
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (bclk_en) begin
            shift_reg <= shift_next;
            if (lr_change) begin
                word <= shift_next;
            end
        end
    end

endmodule

// File: hw/pwm_modulator.sv
`timescale 1ns/1ns

module pwm_modulator #(
    parameter int PWM_BITS = 8
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     frame_valid,
    input  logic signed [audio_pkg::SAMPLE_BITS-1:0] in_l,
    input  logic signed [audio_pkg::SAMPLE_BITS-1:0] in_r,
    output logic                                     pwm_l,
    output logic                                     pwm_r
);
    import audio_pkg::*;

    // Lowest sample bit that reaches the duty
    localparam int LOW_BIT = SAMPLE_BITS - PWM_BITS;

    //////////////////////////////////////////////////
    // Duty conversion
    //////////////////////////////////////////////////

    logic [PWM_BITS-1:0] duty_l_in;
    logic [PWM_BITS-1:0] duty_r_in;

    // Inverted MSB gives offset binary, silence at half duty
    assign duty_l_in = {~in_l[SAMPLE_BITS-1], in_l[SAMPLE_BITS-2:LOW_BIT]};
    assign duty_r_in = {~in_r[SAMPLE_BITS-1], in_r[SAMPLE_BITS-2:LOW_BIT]};

    //////////////////////////////////////////////////
    // Counter and comparators
    //////////////////////////////////////////////////

    logic [PWM_BITS-1:0] pend_l;
    logic [PWM_BITS-1:0] pend_r;
    logic [PWM_BITS-1:0] act_l;
    logic [PWM_BITS-1:0] act_r;
    logic [PWM_BITS-1:0] cnt;
    logic                wrap;
    logic [PWM_BITS-1:0] duty_now_l;
    logic [PWM_BITS-1:0] duty_now_r;

    assign wrap = cnt == '0;
    // New duty already applies on the wrap cycle itself
    assign duty_now_l = wrap ? pend_l : act_l;
    assign duty_now_r = wrap ? pend_r : act_r;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_l <= '0;
            pend_r <= '0;
            act_l  <= '0;
            act_r  <= '0;
            cnt    <= '0;
            pwm_l  <= 1'b0;
            pwm_r  <= 1'b0;
        end else begin
            // Later frame overwrites one not yet applied
            if (frame_valid) begin
                pend_l <= duty_l_in;
                pend_r <= duty_r_in;
            end
            if (wrap) begin
                act_l <= pend_l;
                act_r <= pend_r;
            end
            cnt   <= cnt + 1'b1;
            // Max duty leaves one low cycle per period
            pwm_l <= cnt < duty_now_l;
            pwm_r <= cnt < duty_now_r;
        end
    end

endmodule

// File: hw/sample_align.sv
`timescale 1ns/1ns

module sample_align (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     l_valid,
    input  logic                                     r_valid,
    input  logic [audio_pkg::SAMPLE_BITS-1:0]        word,
    input  logic [7:0]                               word_bits,
    input  audio_pkg::chan_mode_t                    mode,
    output logic                                     frame_valid,
    output logic signed [audio_pkg::SAMPLE_BITS-1:0] out_l,
    output logic signed [audio_pkg::SAMPLE_BITS-1:0] out_r
);
    import audio_pkg::*;

    localparam logic [7:0] FULL_BITS = 8'(SAMPLE_BITS);

    //////////////////////////////////////////////////
    // Barrel shift to left-justified
    //////////////////////////////////////////////////

    logic [7:0]                    shamt;
    logic signed [SAMPLE_BITS-1:0] aligned;

    // Short words move up, long words keep their last 24 bits
    assign shamt   = (word_bits < FULL_BITS) ? FULL_BITS - word_bits : 8'd0;
    // Zero fill below the word's LSB
    assign aligned = word << shamt;

    //////////////////////////////////////////////////
    // Channel mode
    //////////////////////////////////////////////////

    logic signed [SAMPLE_BITS-1:0] held_l;
    logic signed [SAMPLE_BITS:0]   mix_sum;
    logic signed [SAMPLE_BITS-1:0] mix;
    logic signed [SAMPLE_BITS-1:0] next_l;
    logic signed [SAMPLE_BITS-1:0] next_r;

    // One bit of sign extension keeps the sum exact
    assign mix_sum = {held_l[SAMPLE_BITS-1], held_l} + {aligned[SAMPLE_BITS-1], aligned};
    // Dropping the LSB rounds toward minus infinity
    assign mix     = mix_sum[SAMPLE_BITS:1];

    // Right word is on aligned whenever r_valid is high
    always_comb begin
        case (mode)
            MODE_SWAP: begin
                next_l = aligned;
                next_r = held_l;
            end
            MODE_MONO: begin
                next_l = mix;
                next_r = mix;
            end
            default: begin
                next_l = held_l;
                next_r = aligned;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held_l      <= '0;
            out_l       <= '0;
            out_r       <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= r_valid;
            // Left waits here for its right partner
            if (l_valid) begin
                held_l <= aligned;
            end
            if (r_valid) begin
                out_l <= next_l;
                out_r <= next_r;
            end
        end
    end

endmodule

// File: project.f
hw/audio_pkg.sv
hw/i2s_rx.sv
hw/sample_align.sv
hw/pwm_modulator.sv
hw/i2s_pwm_top.sv
tb/tb_clk_gen.sv
tb/i2s_pwm_tb.sv

// File: tb/i2s_pwm_tb.sv
`timescale 1ns/1ns

module i2s_pwm_tb;
    import audio_pkg::*;

    localparam int ROWS    = 12;
    localparam int TIMEOUT = 2000;

    logic                          clk;
    logic                          arst_n;
    logic                          bclk;
    logic                          lrclk;
    logic                          sdata;
    chan_mode_t                    mode;
    logic                          frame_valid;
    logic signed [SAMPLE_BITS-1:0] out_l;
    logic signed [SAMPLE_BITS-1:0] out_r;
    logic [7:0]                    word_bits;
    logic                          pwm_l;
    logic                          pwm_r;

    tb_clk_gen i_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    i2s_pwm_top #(
        .PWM_BITS (8)
    ) i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .bclk        (bclk),
        .lrclk       (lrclk),
        .sdata       (sdata),
        .mode        (mode),
        .frame_valid (frame_valid),
        .out_l       (out_l),
        .out_r       (out_r),
        .word_bits   (word_bits),
        .pwm_l       (pwm_l),
        .pwm_r       (pwm_r)
    );

    //////////////////////////////////////////////////
    // Stimulus table and expected values
    //////////////////////////////////////////////////

    int          row_bits [ROWS];
    chan_mode_t  row_mode [ROWS];
    bit          row_pwm  [ROWS];
    logic [31:0] row_l    [ROWS];
    logic [31:0] row_r    [ROWS];
    logic [23:0] exp_l    [ROWS];
    logic [23:0] exp_r    [ROWS];

    int cyc          = 0;
    int mismatches   = 0;
    int failures     = 0;
    int rise_cyc;
    int fv_cyc;
    bit fv_ok;
    bit frame_seen   = 1'b0;
    bit rows_started = 1'b0;

    // Free-running cycle count for latency checks
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Long words keep only their last 24 bits
    // Short words move up to bit 23
    function automatic logic [23:0] justify(logic [31:0] value, int nbits);
        logic [23:0] w;
        w = value[23:0];
        if (nbits < 24) begin
            w = w << (24 - nbits);
        end
        return w;
    endfunction

    // Top byte in offset binary with silence at 128
    function automatic logic [7:0] duty_of(logic [23:0] x);
        return x[23:16] ^ 8'h80;
    endfunction

    function automatic logic [31:0] rand_word(int nbits);
        logic [31:0] mask;
        mask = (nbits >= 32) ? 32'hffff_ffff : ((32'd1 << nbits) - 32'd1);
        return $urandom() & mask;
    endfunction

    function automatic void set_row(int idx, int nbits, chan_mode_t m, bit pwm,
                                    logic [31:0] l, logic [31:0] r);
        logic [23:0] al;
        logic [23:0] ar;
        int          mean;
        al   = justify(l, nbits);
        ar   = justify(r, nbits);
        // Arithmetic shift of the signed sum floors the mean
        mean = (int'($signed(al)) + int'($signed(ar))) >>> 1;
        row_bits[idx] = nbits;
        row_mode[idx] = m;
        row_pwm[idx]  = pwm;
        row_l[idx]    = l;
        row_r[idx]    = r;
        case (m)
            MODE_SWAP: begin
                exp_l[idx] = ar;
                exp_r[idx] = al;
            end
            MODE_MONO: begin
                exp_l[idx] = mean[23:0];
                exp_r[idx] = mean[23:0];
            end
            default: begin
                exp_l[idx] = al;
                exp_r[idx] = ar;
            end
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    //////////////////////////////////////////////////
    // I2S serializer
    //////////////////////////////////////////////////

    // Four clk low with new data and then four clk high
    task automatic drive_bit(logic value, logic lr);
        @(posedge clk);
        #2;
        bclk  = 1'b0;
        sdata = value;
        lrclk = lr;
        repeat (4) @(posedge clk);
        #2;
        bclk     = 1'b1;
        rise_cyc = cyc;
        repeat (3) @(posedge clk);
    endtask

    // MSB first with lrclk flipping on the last bit
    task automatic send_word(logic [31:0] value, int nbits, logic lr);
        for (int i = nbits - 1; i >= 0; i--) begin
            drive_bit(value[i], (i == 0) ? ~lr : lr);
        end
    endtask

    task automatic wait_frame();
        int n;
        n     = 0;
        fv_ok = 1'b0;
        while (!fv_ok && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
            if (frame_valid) begin
                fv_ok  = 1'b1;
                fv_cyc = cyc;
            end
        end
        assert (fv_ok) else begin
            $display("ERROR t=%0t frame_valid never came after a stereo frame", $time);
            failures++;
        end
    endtask

    //////////////////////////////////////////////////
    // PWM duty measurement
    //////////////////////////////////////////////////

    task automatic measure_pwm(logic [7:0] duty_l, logic [7:0] duty_r);
        int   edges;
        int   n;
        int   high_l;
        int   high_r;
        logic prev_l;
        logic prev_r;
        edges  = 0;
        n      = 0;
        prev_l = pwm_l;
        prev_r = pwm_r;
        // Rising edges only happen at the counter wrap
        while (edges < 2 && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
            if ((pwm_l && !prev_l) || (pwm_r && !prev_r)) begin
                edges++;
            end
            prev_l = pwm_l;
            prev_r = pwm_r;
        end
        assert (edges == 2) else begin
            $display("ERROR t=%0t PWM counter wrap was not seen twice", $time);
            failures++;
        end
        if (edges == 2) begin
            high_l = int'(pwm_l);
            high_r = int'(pwm_r);
            repeat (255) begin
                @(posedge clk);
                #1;
                high_l = high_l + int'(pwm_l);
                high_r = high_r + int'(pwm_r);
            end
            check_value("pwm_l high cycles", {24'h0, duty_l}, high_l);
            check_value("pwm_r high cycles", {24'h0, duty_r}, high_r);
        end
    endtask

    task automatic run_row(int i);
        @(posedge clk);
        #2;
        mode = row_mode[i];
        fork
            begin
                send_word(row_l[i], row_bits[i], 1'b0);
                send_word(row_r[i], row_bits[i], 1'b1);
            end
            wait_frame();
        join
        if (fv_ok) begin
            check_value("frame_valid latency", 32'd5, fv_cyc - rise_cyc);
            check_value("word_bits", row_bits[i], {24'h0, word_bits});
            check_value("out_l", {8'h00, exp_l[i]}, {8'h00, out_l});
            check_value("out_r", {8'h00, exp_r[i]}, {8'h00, out_r});
            if (row_pwm[i]) begin
                measure_pwm(duty_of(exp_l[i]), duty_of(exp_r[i]));
            end
        end
    endtask

    // Everything stays quiet between reset and the first frame
    always @(negedge clk) begin
        if (arst_n && !frame_seen) begin
            if (frame_valid && rows_started) begin
                frame_seen = 1'b1;
            end else begin
                check_value("frame_valid", 32'd0, {31'd0, frame_valid});
                check_value("pwm_l", 32'd0, {31'd0, pwm_l});
                check_value("pwm_r", 32'd0, {31'd0, pwm_r});
                check_value("out_l", 32'd0, {8'h00, out_l});
                check_value("out_r", 32'd0, {8'h00, out_r});
            end
        end
    end

    initial begin
        int n;
        bclk  = 1'b0;
        lrclk = 1'b0;
        sdata = 1'b0;
        mode  = MODE_STEREO;
        void'($urandom(32'h75b5));
        set_row(0, 24, MODE_STEREO, 1'b1, rand_word(24), rand_word(24));
        set_row(1, 24, MODE_STEREO, 1'b0, rand_word(24), rand_word(24));
        set_row(2, 16, MODE_STEREO, 1'b0, rand_word(16), rand_word(16));
        set_row(3, 18, MODE_STEREO, 1'b0, rand_word(18), rand_word(18));
        set_row(4, 32, MODE_STEREO, 1'b0, rand_word(32), rand_word(32));
        set_row(5, 24, MODE_SWAP, 1'b0, rand_word(24), rand_word(24));
        set_row(6, 16, MODE_SWAP, 1'b0, rand_word(16), rand_word(16));
        set_row(7, 24, MODE_MONO, 1'b0, rand_word(24), rand_word(24));
        set_row(8, 18, MODE_MONO, 1'b0, rand_word(18), rand_word(18));
        set_row(9, 32, MODE_MONO, 1'b1, rand_word(32), rand_word(32));
        // Full negative left gives duty 0 and max positive right gives 255
        set_row(10, 24, MODE_STEREO, 1'b1, 32'h0080_0000, 32'h007f_ffff);
        set_row(11, 16, MODE_STEREO, 1'b1, 32'h0000_8000, 32'h0000_7fff);
        n = 0;
        while (!arst_n && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        assert (arst_n) else begin
            $display("ERROR t=%0t reset was never released", $time);
            failures++;
        end
        // Idle span of a few PWM periods before any frame
        repeat (600) @(posedge clk);
        rows_started = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            run_row(i);
        end
        $display("Done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);
    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset low for two clock cycles, released off the edge
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
    end

endmodule
